/* verilog.f */
src/dcache_pkg.sv
src/dcache_req_buf.sv
src/dcache_ways.sv
src/dcache_fsm.sv
src/dcache_rdata_sel.sv
src/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_props.sv
dv/dcache_tb.sv

/* Makefile */
TOP := dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* dv/dcache_tb.sv */
// testbench for the data cache top; runs a directed and random operation table against memory
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*; ();

    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic [31:0] exp_rdata;
        logic        chk_fill;
        logic        exp_fill;
    } op_t;

    logic                 clk;
    logic                 rstn;
    logic                 req_valid;
    dcache_req_t          req;
    logic                 req_ready;
    logic                 rsp_valid;
    logic [31:0]          rsp_rdata;
    logic                 mem_req;
    dcache_mem_req_t      mem_cmd;
    logic                 mem_addr_ok;
    logic                 mem_data_ok;
    logic [LINE_BITS-1:0] mem_line;

    op_t             ops[$];
    logic [31:0]     ref_mem [logic [29:0]];
    logic            table_ready = 1'b0;
    integer          seed;
    int              rd_cnt = 0;
    int              wr_cnt = 0;
    dcache_mem_req_t last_wr;
    dcache_mem_req_t last_rd;

    dcache_top UUT (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    dcache_mem_model u_mem (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_line    (mem_line)
    );

    bind dcache_fsm dcache_props u_props (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_cmd     (mem_cmd),
        .hit         (hit)
    );

    always #4 clk = ~clk;

    // memory traffic seen at the cache boundary, counted per accept
    always @(negedge clk) begin
        if (rstn && mem_req && mem_addr_ok) begin
            if (mem_cmd.write) begin
                wr_cnt  <= wr_cnt + 1;
                last_wr <= mem_cmd;
            end else begin
                rd_cnt  <= rd_cnt + 1;
                last_rd <= mem_cmd;
            end
        end
    end

    task automatic report_error_and_stop(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference memory and operation table
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                              input logic [INDEX_WIDTH-1:0] index,
                                              input logic [OFFSET_WIDTH-1:0] offset);
        return {tag, index, offset, 2'b00};
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
    endfunction

    task automatic add_read(input logic [31:0] addr, input logic chk_fill,
                            input logic exp_fill);
        op_t op;
        op           = '0;
        op.addr      = addr;
        op.exp_rdata = ref_word(addr);
        op.chk_fill  = chk_fill;
        op.exp_fill  = exp_fill;
        ops.push_back(op);
    endtask

    task automatic add_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        op_t         op;
        logic [31:0] word;
        word = ref_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        ref_mem[addr[31:2]] = word;
        op       = '0;
        op.write = 1'b1;
        op.addr  = addr;
        op.wdata = data;
        op.wstrb = strb;
        ops.push_back(op);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] addr;
        // miss then hit in one line, set 1
        add_read(make_addr(24'h00001a, 4'h1, 2'd2), 1'b1, 1'b1);
        add_read(make_addr(24'h00001a, 4'h1, 2'd3), 1'b1, 1'b0);
        // write hit under strobes, read back from the cache
        add_write(make_addr(24'h00001a, 4'h1, 2'd2), 32'hcafef00d, 4'b0101);
        add_read(make_addr(24'h00001a, 4'h1, 2'd2), 1'b1, 1'b0);
        // write miss goes around the cache
        add_write(make_addr(24'h00002b, 4'h2, 2'd1), 32'h12345678, 4'b0011);
        add_read(make_addr(24'h00002b, 4'h2, 2'd1), 1'b1, 1'b1);
        // lines a, b, c compete for set 3
        add_read(make_addr(24'h00003a, 4'h3, 2'd0), 1'b1, 1'b1);
        add_read(make_addr(24'h00003b, 4'h3, 2'd0), 1'b1, 1'b1);
        add_read(make_addr(24'h00003a, 4'h3, 2'd0), 1'b1, 1'b0);
        add_read(make_addr(24'h00003c, 4'h3, 2'd0), 1'b1, 1'b1);
        add_read(make_addr(24'h00003a, 4'h3, 2'd0), 1'b1, 1'b0);
        add_read(make_addr(24'h00003b, 4'h3, 2'd0), 1'b1, 1'b1);
        // random mix, four tags over sets 8 and 9
        for (int n = 0; n < 48; n++) begin
            r    = $random(seed);
            addr = make_addr(24'h000040 | {22'd0, r[1:0]}, {3'b100, r[2]}, r[4:3]);
            if (r[5]) begin
                d = $random(seed);
                add_write(addr, d, r[11:8]);
            end else begin
                add_read(addr, 1'b0, 1'b0);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one operation from request to idle
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_op(input op_t op);
        int          rd_before;
        int          wr_before;
        int          rsp_seen;
        logic [31:0] rdata;
        logic        done;
        rd_before    = rd_cnt;
        wr_before    = wr_cnt;
        rsp_seen     = 0;
        rdata        = '0;
        done         = 1'b0;
        req_valid    = 1'b1;
        req.write    = op.write;
        req.addr.raw = op.addr;
        req.wdata    = op.wdata;
        req.wstrb    = op.wstrb;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        while (!done) begin
            if (rsp_valid) begin
                rsp_seen++;
                rdata = rsp_rdata;
            end
            if (req_ready) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        if (op.write) begin
            assert (wr_cnt - wr_before == 1) else report_error_and_stop($sformatf(
                "write to %h reached memory %0d times", op.addr, wr_cnt - wr_before));
            assert (last_wr.addr.raw == op.addr) else report_error_and_stop($sformatf(
                "Error: mem_cmd.addr = %h, expected %h", last_wr.addr.raw, op.addr));
            assert (last_wr.wdata == op.wdata) else report_error_and_stop($sformatf(
                "Error: mem_cmd.wdata = %h, expected %h", last_wr.wdata, op.wdata));
            assert (last_wr.wstrb == op.wstrb) else report_error_and_stop($sformatf(
                "Error: mem_cmd.wstrb = %h, expected %h", last_wr.wstrb, op.wstrb));
            assert (rsp_seen == 0 && rd_cnt == rd_before) else report_error_and_stop(
                $sformatf("write to %h gave a response or a line read", op.addr));
        end else begin
            assert (rsp_seen == 1) else report_error_and_stop($sformatf(
                "read of %h gave %0d response strobes", op.addr, rsp_seen));
            assert (rdata == op.exp_rdata) else report_error_and_stop($sformatf(
                "Error: rsp_rdata = %h, expected %h at %h", rdata, op.exp_rdata, op.addr));
            assert (wr_cnt == wr_before && rd_cnt - rd_before <= 1) else
                report_error_and_stop($sformatf("read of %h caused extra memory traffic",
                                                op.addr));
            // a line read asks for the line base
            if (rd_cnt - rd_before == 1) begin
                assert (last_rd.addr.raw == {op.addr[31:4], 4'h0}) else
                    report_error_and_stop($sformatf("Error: mem_cmd.addr = %h, expected %h",
                                                    last_rd.addr.raw, {op.addr[31:4], 4'h0}));
            end
            if (op.chk_fill) begin
                assert (rd_cnt - rd_before == (op.exp_fill ? 1 : 0)) else
                    report_error_and_stop($sformatf("read of %h made %0d line reads",
                                                    op.addr, rd_cnt - rd_before));
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        seed      = 32'hdcc1;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        assert (req_ready == 1'b1) else report_error_and_stop($sformatf(
            "Error: req_ready = %h after reset, expected 1", req_ready));
        assert (mem_req == 1'b0) else report_error_and_stop($sformatf(
            "Error: mem_req = %h after reset, expected 0", mem_req));
        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        $display("Test passed");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        wait (table_ready);
        repeat (ops.size() * 40) @(posedge clk);
        $display("timeout, the operation table did not finish in %0d cycles", ops.size() * 40);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* dv/dcache_props.sv */
// concurrent checks on the cache control fsm; bound into dcache_fsm from the testbench
`timescale 1ns/1ps

module dcache_props import dcache_pkg::*; (
    input logic            clk,
    input logic            rstn,
    input logic            mem_req,
    input logic            mem_addr_ok,
    input dcache_mem_req_t mem_cmd,
    input logic [WAYS-1:0] hit
);

    // a waiting memory request keeps its command until accepted
    mem_req_held: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_addr_ok) |=> (mem_req && $stable(mem_cmd)))
    else $error("mem_req dropped or mem_cmd changed before mem_addr_ok");

    // a line lives in one way only
    hit_onehot: assert property (@(posedge clk) disable iff (!rstn)
        !(hit[0] && hit[1]))
    else $error("hit is high for both ways");

    reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> !mem_req)
    else $error("mem_req is high in the first cycle after reset");

endmodule

/* dv/dcache_mem_model.sv */
// next-level memory model for the data cache testbench with random accept and return delays
`timescale 1ns/1ps

module dcache_mem_model import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 mem_req,
    input  dcache_mem_req_t      mem_cmd,
    output logic                 mem_addr_ok,
    output logic                 mem_data_ok,
    output logic [LINE_BITS-1:0] mem_line
);

    logic [31:0]          store [logic [29:0]];
    integer               seed;
    logic [1:0]           addr_cnt;
    logic [1:0]           data_cnt;
    logic                 pending;
    logic [LINE_BITS-1:0] line_q;

    initial seed = 32'hdcc1;

    // untouched words follow the fill pattern of their word address
    function automatic logic [31:0] read_word(input logic [29:0] wa);
        if (store.exists(wa)) begin
            return store[wa];
        end
        return {2'b00, wa} ^ 32'h5a5a0000;
    endfunction

    assign mem_addr_ok = mem_req && (addr_cnt == 2'd0);
    assign mem_data_ok = pending && (data_cnt == 2'd0);
    assign mem_line    = line_q;

    always @(posedge clk or negedge rstn) begin : seq
        logic [31:0] rnd;
        logic [31:0] word;
        if (!rstn) begin
            addr_cnt <= 2'd0;
            data_cnt <= 2'd0;
            pending  <= 1'b0;
            line_q   <= '0;
        end else begin
            rnd = $random(seed);
            // new accept delay drawn while idle and after each accept
            if (!mem_req || mem_addr_ok) begin
                addr_cnt <= rnd[1:0];
            end else begin
                addr_cnt <= addr_cnt - 2'd1;
            end
            if (mem_req && mem_addr_ok) begin
                if (mem_cmd.write) begin
                    word = read_word(mem_cmd.addr.raw[31:2]);
                    for (int b = 0; b < 4; b++) begin
                        if (mem_cmd.wstrb[b]) begin
                            word[b*8 +: 8] = mem_cmd.wdata[b*8 +: 8];
                        end
                    end
                    store[mem_cmd.addr.raw[31:2]] = word;
                end else begin
                    pending  <= 1'b1;
                    data_cnt <= rnd[3:2];
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        line_q[i*32 +: 32] <= read_word({mem_cmd.addr.raw[31:4], i[1:0]});
                    end
                end
            end else if (pending) begin
                if (data_cnt == 2'd0) begin
                    pending <= 1'b0;
                end else begin
                    data_cnt <= data_cnt - 2'd1;
                end
            end
        end
    end

endmodule

/* src/dcache_top.sv */
// top of the two-way write-through data cache; pipeline request port and next-level memory port
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 req_valid,
    input  dcache_req_t          req,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output logic [31:0]          rsp_rdata,
    output logic                 mem_req,
    output dcache_mem_req_t      mem_cmd,
    input  logic                 mem_addr_ok,
    input  logic                 mem_data_ok,
    input  logic [LINE_BITS-1:0] mem_line
);

    dcache_req_t           held;
    dcache_ctl_t           ctl;
    logic                  load;
    logic [WAYS-1:0]       hit;
    logic                  victim;
    logic [WAYS-1:0][31:0] way_words;

    // decode
    dcache_req_buf u_req_buf (
        .clk  (clk),
        .rstn (rstn),
        .req  (req),
        .load (load),
        .held (held)
    );

    // execute
    dcache_fsm u_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .held        (held),
        .hit         (hit),
        .victim      (victim),
        .mem_req     (mem_req),
        .mem_cmd     (mem_cmd),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .load        (load),
        .ctl         (ctl)
    );

    // arrays read on the incoming index so tags are ready in lookup
    dcache_ways u_ways (
        .clk          (clk),
        .rstn         (rstn),
        .lookup_index (req.addr.f.index),
        .held         (held),
        .ctl          (ctl),
        .mem_line     (mem_line),
        .hit          (hit),
        .victim       (victim),
        .way_words    (way_words)
    );

    // result
    dcache_rdata_sel u_rdata_sel (
        .ctl       (ctl),
        .hit       (hit),
        .held      (held),
        .way_words (way_words),
        .mem_line  (mem_line),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata)
    );

endmodule

/* src/dcache_rdata_sel.sv */
// read data selector of the data cache; picks the hit word or the refill word and strobes it out
`timescale 1ns/1ps

module dcache_rdata_sel import dcache_pkg::*; (
    input  dcache_ctl_t           ctl,
    input  logic [WAYS-1:0]       hit,
    input  dcache_req_t           held,
    input  logic [WAYS-1:0][31:0] way_words,
    input  logic [LINE_BITS-1:0]  mem_line,
    output logic                  rsp_valid,
    output logic [31:0]           rsp_rdata
);

    logic [31:0] hit_word;
    logic [31:0] line_word;

    // at most one way hits
    assign hit_word = hit[1] ? way_words[1] : way_words[0];

    // requested word out of the returning line
    assign line_word = mem_line[held.addr.f.offset*32 +: 32];

    assign rsp_rdata = ctl.rsp_from_mem ? line_word : hit_word;
    assign rsp_valid = ctl.rsp_strobe;

endmodule

/* src/dcache_fsm.sv */
// main control fsm of the data cache; sequences lookups, misses and memory handshakes
`timescale 1ns/1ps

module dcache_fsm import dcache_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            req_valid,
    output logic            req_ready,
    input  dcache_req_t     held,
    input  logic [WAYS-1:0] hit,
    input  logic            victim,
    output logic            mem_req,
    output dcache_mem_req_t mem_cmd,
    input  logic            mem_addr_ok,
    input  logic            mem_data_ok,
    output logic            load,
    output dcache_ctl_t     ctl
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT_W,
        MISS_R,
        MISS_WAIT,
        MISS_W
    } state_t;

    state_t state;
    state_t next_state;
    logic   any_hit;
    logic   hit_way;

    assign any_hit = |hit;
    assign hit_way = hit[1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // next state, handshakes and array controls
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        req_ready  = 1'b0;
        mem_req    = 1'b0;
        ctl        = '0;
        case (state)
            IDLE: begin
                req_ready  = 1'b1;
                next_state = req_valid ? LOOKUP : IDLE;
            end
            LOOKUP: begin
                if (!any_hit) begin
                    next_state = held.write ? MISS_W : MISS_R;
                end else if (!held.write) begin
                    // read hit answers now and lets the next request in
                    ctl.rsp_strobe = 1'b1;
                    ctl.lru_touch  = 1'b1;
                    ctl.lru_way    = hit_way;
                    req_ready      = 1'b1;
                    next_state     = req_valid ? LOOKUP : IDLE;
                end else begin
                    ctl.data_we   = hit;
                    ctl.lru_touch = 1'b1;
                    ctl.lru_way   = hit_way;
                    next_state    = HIT_W;
                end
            end
            // write through, cache already updated
            HIT_W, MISS_W: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    req_ready  = 1'b1;
                    next_state = req_valid ? LOOKUP : IDLE;
                end
            end
            MISS_R: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (mem_data_ok) begin
                    ctl.refill          = 1'b1;
                    ctl.data_we[victim] = 1'b1;
                    ctl.tag_we[victim]  = 1'b1;
                    ctl.lru_touch       = 1'b1;
                    ctl.lru_way         = victim;
                    ctl.rsp_strobe      = 1'b1;
                    ctl.rsp_from_mem    = 1'b1;
                    req_ready           = 1'b1;
                    next_state          = req_valid ? LOOKUP : IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    assign load = req_ready && req_valid;

    // memory command comes from the held request, so it is stable while mem_req waits
    always_comb begin
        mem_cmd.write = held.write;
        mem_cmd.addr  = held.addr;
        mem_cmd.wdata = held.wdata;
        mem_cmd.wstrb = held.wstrb;
        if (!held.write) begin
            // whole line read
            mem_cmd.addr.f.offset   = '0;
            mem_cmd.addr.f.byte_off = '0;
            mem_cmd.wstrb           = '0;
        end
    end

endmodule

/* src/dcache_ways.sv */
// tag, valid, data and lru storage of the two-way data cache with per-way hit detection
`timescale 1ns/1ps

module dcache_ways import dcache_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [INDEX_WIDTH-1:0] lookup_index,
    input  dcache_req_t           held,
    input  dcache_ctl_t           ctl,
    input  logic [LINE_BITS-1:0]  mem_line,
    output logic [WAYS-1:0]       hit,
    output logic                  victim,
    output logic [WAYS-1:0][31:0] way_words
);

    logic [INDEX_WIDTH-1:0]  wr_idx;
    logic [OFFSET_WIDTH-1:0] wr_off;
    logic                    same_set;
    logic [SETS-1:0]         lru;

    // all writes go to the held request's set
    assign wr_idx   = held.addr.f.index;
    assign wr_off   = held.addr.f.offset;
    assign same_set = (wr_idx == lookup_index);

    ////////////////////////////////////////////////////////////////////////////
    // per-way arrays
    ////////////////////////////////////////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [TAG_WIDTH-1:0] tag_mem [SETS];
        logic [LINE_BITS-1:0] data_mem [SETS];
        logic [SETS-1:0]      valid;
        logic [TAG_WIDTH-1:0] tag_rd;
        logic [LINE_BITS-1:0] line_rd;
        logic                 valid_rd;
        logic [LINE_BITS-1:0] wr_line;

        // refill takes the whole line, a write hit merges bytes into the word
        always_comb begin
            wr_line = line_rd;
            for (int b = 0; b < 4; b++) begin
                if (held.wstrb[b]) begin
                    wr_line[wr_off*32 + b*8 +: 8] = held.wdata[b*8 +: 8];
                end
            end
            if (ctl.refill) begin
                wr_line = mem_line;
            end
        end

        // synchronous read, write-first when a new request hits the set being written
        always_ff @(posedge clk) begin
            if (ctl.data_we[w]) begin
                data_mem[wr_idx] <= wr_line;
            end
            if (ctl.tag_we[w]) begin
                tag_mem[wr_idx] <= held.addr.f.tag;
            end
            if (ctl.data_we[w] && same_set) begin
                line_rd <= wr_line;
            end else begin
                line_rd <= data_mem[lookup_index];
            end
            if (ctl.tag_we[w] && same_set) begin
                tag_rd <= held.addr.f.tag;
            end else begin
                tag_rd <= tag_mem[lookup_index];
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid    <= '0;
                valid_rd <= 1'b0;
            end else begin
                if (ctl.tag_we[w]) begin
                    valid[wr_idx] <= 1'b1;
                end
                valid_rd <= (ctl.tag_we[w] && same_set) ? 1'b1 : valid[lookup_index];
            end
        end

        assign hit[w]       = valid_rd && (tag_rd == held.addr.f.tag);
        assign way_words[w] = line_rd[wr_off*32 +: 32];
    end

    ////////////////////////////////////////////////////////////////////////////
    // lru, one bit per set naming the next victim
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru <= '0;
        end else if (ctl.lru_touch) begin
            // point at the way not just used
            lru[wr_idx] <= ~ctl.lru_way;
        end
    end

    assign victim = lru[wr_idx];

endmodule

/* src/dcache_req_buf.sv */
// request buffer of the data cache; holds the accepted request for the whole operation
`timescale 1ns/1ps

module dcache_req_buf import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  dcache_req_t req,
    input  logic        load,
    output dcache_req_t held
);

    // load is ready and valid together, straight from the fsm.
    // the held copy stays put across a miss until the next accept
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            held <= '0;
        end else if (load) begin
            held <= req;
        end
    end

    // consumers read held.addr.f.tag / index / offset directly,
    // memory takes held.addr.raw

endmodule

/* src/dcache_pkg.sv */
// shared widths, request and control structs for the data cache; import in every cache module
package dcache_pkg;

    // geometry
    localparam int INDEX_WIDTH  = 4;
    localparam int OFFSET_WIDTH = 2;
    localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int WAYS         = 2;
    localparam int LINE_WORDS   = 4;
    localparam int LINE_BITS    = 128;
    localparam int SETS         = 1 << INDEX_WIDTH;

    // lookup view of an address
    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
        logic [1:0]              byte_off;
    } dcache_addr_f_t;

    // raw word goes to memory, fields drive the lookup
    typedef union packed {
        logic [31:0]    raw;
        dcache_addr_f_t f;
    } dcache_addr_u;

    typedef struct packed {
        logic         write;
        dcache_addr_u addr;
        logic [31:0]  wdata;
        logic [3:0]   wstrb;
    } dcache_req_t;

    // read addresses are line aligned
    typedef struct packed {
        logic         write;
        dcache_addr_u addr;
        logic [31:0]  wdata;
        logic [3:0]   wstrb;
    } dcache_mem_req_t;

    typedef struct packed {
        logic [WAYS-1:0] data_we;
        logic [WAYS-1:0] tag_we;
        logic            refill;
        logic            lru_touch;
        logic            lru_way;
        logic            rsp_strobe;
        logic            rsp_from_mem;
    } dcache_ctl_t;

endpackage
